/* mdu_cfg.svh */
`ifndef MDU_CFG_SVH
`define MDU_CFG_SVH

`define MDU_XLEN        32
`define MDU_TAG_W       4
`define MDU_IN_DEPTH    4
`define MDU_RES_DEPTH   4
`define MDU_MUL_STAGES  3

// limit is saturated to the result queue depth
`define MDU_CREDITS_RST `MDU_RES_DEPTH
`define MDU_CRED_W      ($clog2(`MDU_RES_DEPTH + 1))

`endif

/* mdu_pkg.sv */
`default_nettype none

`include "mdu_cfg.svh"

package mdu_pkg;

    // top bit set for divides
    typedef enum logic [2:0] {
        MDU_MUL    = 3'b000,
        MDU_MULH   = 3'b001,
        MDU_MULHSU = 3'b010,
        MDU_MULHU  = 3'b011,
        MDU_DIV    = 3'b100,
        MDU_DIVU   = 3'b101,
        MDU_REM    = 3'b110,
        MDU_REMU   = 3'b111
    } mdu_op_e;

    typedef struct packed {
        mdu_op_e                op;
        logic [`MDU_XLEN-1:0]   a;
        logic [`MDU_XLEN-1:0]   b;
        logic [`MDU_TAG_W-1:0]  tag;
    } mdu_req_t;

    typedef struct packed {
        logic [`MDU_XLEN-1:0]   data;
        logic [`MDU_TAG_W-1:0]  tag;
    } mdu_res_t;

endpackage

`default_nettype wire

/* mdu_op_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_cfg.svh"

interface mdu_op_if;

    logic               valid;
    logic               ready;
    mdu_pkg::mdu_req_t  req;

    modport src (
        output valid,
        output req,
        input  ready
    );

    modport dst (
        input  valid,
        input  req,
        output ready
    );

endinterface

`default_nettype wire

/* mdu_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_cfg.svh"

module mdu_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = `MDU_IN_DEPTH
) (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         push_i,
    input  wire T                       push_data_i,
    input  wire                         pop_i,
    output T                            data_o,
    output logic                        empty_o,
    output logic                        full_o,
    output logic [$clog2(DEPTH+1)-1:0]  count_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T                mem [DEPTH];
    logic [AW-1:0]   wr_ptr_q;
    logic [AW-1:0]   rd_ptr_q;
    logic [CW-1:0]   cnt_q;

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    assign data_o  = mem[rd_ptr_q]; // head, valid when not empty
    assign empty_o = (cnt_q == '0);
    assign full_o  = (cnt_q == CW'(DEPTH));
    assign count_o = cnt_q;

    // producers upstream must hold back on their own
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        push_i |-> !full_o);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* mdu_muler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_cfg.svh"

module mdu_muler (
    input  wire                 clk,
    input  wire                 rst_n_i,
    input  wire                 valid_i,
    input  wire mdu_pkg::mdu_req_t req_i,
    output logic                valid_o,
    output mdu_pkg::mdu_res_t   res_o
);

    localparam int W = `MDU_XLEN;

    logic                   a_sx;
    logic                   b_sx;
    logic                   v1_q, v2_q, v3_q;
    logic signed [W:0]      a1_q, b1_q;
    logic signed [2*W+1:0]  p2_q;
    mdu_pkg::mdu_op_e       op1_q, op2_q;
    logic [`MDU_TAG_W-1:0]  tag1_q, tag2_q;
    mdu_pkg::mdu_res_t      res3_q;

    // MUL only needs the low word, extension does not matter there
    assign a_sx = ((req_i.op == mdu_pkg::MDU_MULH) || (req_i.op == mdu_pkg::MDU_MULHSU))
                  && req_i.a[W-1];
    assign b_sx = (req_i.op == mdu_pkg::MDU_MULH) && req_i.b[W-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
            v3_q <= 1'b0;
        end else begin
            v1_q <= valid_i;
            v2_q <= v1_q;
            v3_q <= v2_q;
        end
    end

    always_ff @(posedge clk) begin
        a1_q   <= {a_sx, req_i.a}; // stage 1: extend
        b1_q   <= {b_sx, req_i.b};
        op1_q  <= req_i.op;
        tag1_q <= req_i.tag;
        p2_q   <= a1_q * b1_q; // stage 2: 66-bit product
        op2_q  <= op1_q;
        tag2_q <= tag1_q;
        res3_q.data <= (op2_q == mdu_pkg::MDU_MUL) ? p2_q[W-1:0] : p2_q[2*W-1:W];
        res3_q.tag  <= tag2_q;
    end

    assign valid_o = v3_q;
    assign res_o   = res3_q;

endmodule

`default_nettype wire

/* mdu_diver.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_cfg.svh"

module mdu_diver (
    input  wire                 clk,
    input  wire                 rst_n_i,
    input  wire                 start_i,
    input  wire mdu_pkg::mdu_req_t req_i,
    output logic                busy_o,
    output logic                done_o,
    output mdu_pkg::mdu_res_t   res_o
);

    localparam int W = `MDU_XLEN;

    logic                   sgn;
    logic [W-1:0]           a_mag, b_mag;
    logic [W:0]             shifted;
    logic [W+1:0]           diff;
    logic [W-1:0]           quo_fix, rem_fix;
    logic                   busy_q, done_q;
    logic [$clog2(W+1)-1:0] cnt_q;
    logic [W-1:0]           quo_q, rem_q, dvs_q, dvd_q;
    logic                   neg_q_q, neg_r_q, dz_q, rem_sel_q;
    logic [`MDU_TAG_W-1:0]  tag_q;

    assign sgn   = (req_i.op == mdu_pkg::MDU_DIV) || (req_i.op == mdu_pkg::MDU_REM);
    assign a_mag = (sgn && req_i.a[W-1]) ? -req_i.a : req_i.a;
    assign b_mag = (sgn && req_i.b[W-1]) ? -req_i.b : req_i.b;

    assign shifted = {rem_q, quo_q[W-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dvs_q}; // msb set on borrow

    // most negative / -1 lands on the dividend with no special case
    assign quo_fix = neg_q_q ? -quo_q : quo_q;
    assign rem_fix = neg_r_q ? -rem_q : rem_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == W) begin // sign fix cycle
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            quo_q     <= a_mag;
            rem_q     <= '0;
            dvs_q     <= b_mag;
            dvd_q     <= req_i.a;
            neg_q_q   <= sgn && (req_i.a[W-1] ^ req_i.b[W-1]);
            neg_r_q   <= sgn && req_i.a[W-1];
            dz_q      <= (req_i.b == '0);
            rem_sel_q <= req_i.op[1];
            tag_q     <= req_i.tag;
        end else if (busy_q && (cnt_q < W)) begin
            quo_q <= {quo_q[W-2:0], ~diff[W+1]};
            rem_q <= diff[W+1] ? shifted[W-1:0] : diff[W-1:0];
        end
    end

    always_comb begin
        res_o.tag = tag_q;
        if (dz_q) begin
            res_o.data = rem_sel_q ? dvd_q : '1; // divide by zero
        end else begin
            res_o.data = rem_sel_q ? rem_fix : quo_fix;
        end
    end

    assign busy_o = busy_q;
    assign done_o = done_q;

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n_i)
        start_i |-> !busy_o);
    a_done_time: assert property (@(posedge clk) disable iff (!rst_n_i)
        start_i |=> busy_o [*33] ##1 done_o);

endmodule

`default_nettype wire

/* mdu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_cfg.svh"

module mdu (
    input  wire                         clk,
    input  wire                         rst_n_i,
    mdu_op_if.dst                       op,
    input  wire [`MDU_CRED_W-1:0]       credit_limit_i,
    input  wire                         res_credit_i,
    output logic                        res_valid_o,
    output mdu_pkg::mdu_res_t           res_o
);

    logic                       is_div, room, fire, send, push;
    logic                       mul_valid, div_busy, div_done, res_empty;
    logic [`MDU_CRED_W-1:0]     inflight_q, out_q, res_cnt;
    logic [`MDU_CRED_W:0]       used;
    mdu_pkg::mdu_res_t          mul_res, div_res, push_res;

    assign is_div = op.req.op[2];
    assign used   = inflight_q + res_cnt; // reserved result slots
    assign room   = (used < `MDU_RES_DEPTH);

    // divides wait for the multiplier to drain
    assign op.ready = room && !div_busy && (!is_div || (inflight_q == '0));
    assign fire     = op.valid && op.ready;

    mdu_muler u_muler (
        .clk,
        .rst_n_i,
        .valid_i (fire && !is_div),
        .req_i   (op.req),
        .valid_o (mul_valid),
        .res_o   (mul_res)
    );

    mdu_diver u_diver (
        .clk,
        .rst_n_i,
        .start_i (fire && is_div),
        .req_i   (op.req),
        .busy_o  (div_busy),
        .done_o  (div_done),
        .res_o   (div_res)
    );

    assign push     = mul_valid || div_done;
    assign push_res = mul_valid ? mul_res : div_res;
    assign send     = !res_empty && (out_q < credit_limit_i);

    mdu_fifo #(
        .T     (mdu_pkg::mdu_res_t),
        .DEPTH (`MDU_RES_DEPTH)
    ) u_res_fifo (
        .clk,
        .rst_n_i,
        .push_i      (push),
        .push_data_i (push_res),
        .pop_i       (send),
        .data_o      (res_o),
        .empty_o     (res_empty),
        .full_o      (),
        .count_o     (res_cnt)
    );

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inflight_q <= '0;
            out_q      <= '0;
        end else begin
            case ({fire, push})
                2'b10:   inflight_q <= inflight_q + 1'b1;
                2'b01:   inflight_q <= inflight_q - 1'b1;
                default: inflight_q <= inflight_q;
            endcase
            case ({send, res_credit_i})
                2'b10:   out_q <= out_q + 1'b1;
                2'b01:   out_q <= out_q - 1'b1;
                default: out_q <= out_q;
            endcase
        end
    end

    assign res_valid_o = send;

    a_one_writer: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(mul_valid && div_done));
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        (out_q <= credit_limit_i) ##1 $stable(credit_limit_i) |-> (out_q <= credit_limit_i));

endmodule

`default_nettype wire

/* mdu_csr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_cfg.svh"

module mdu_csr (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         cfg_we_i,
    input  wire                         cfg_addr_i,
    input  wire [`MDU_XLEN-1:0]         cfg_wdata_i,
    output logic [`MDU_XLEN-1:0]        cfg_rdata_o,
    input  wire                         res_valid_i,
    output logic [`MDU_CRED_W-1:0]      credit_limit_o
);

    localparam int CW = `MDU_CRED_W;

    logic [CW-1:0]          limit_q;
    logic [`MDU_XLEN-1:0]   done_cnt_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            limit_q    <= CW'(`MDU_CREDITS_RST);
            done_cnt_q <= '0;
        end else begin
            if (cfg_we_i && !cfg_addr_i) begin // addr 1 is read only
                limit_q <= (cfg_wdata_i > `MDU_RES_DEPTH) ? CW'(`MDU_RES_DEPTH)
                                                          : cfg_wdata_i[CW-1:0];
            end
            if (res_valid_i) begin
                done_cnt_q <= done_cnt_q + 1'b1;
            end
        end
    end

    assign cfg_rdata_o    = cfg_addr_i ? done_cnt_q : `MDU_XLEN'(limit_q);
    assign credit_limit_o = limit_q;

endmodule

`default_nettype wire

/* mdu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_cfg.svh"

module mdu_top (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         req_valid_i,
    input  wire mdu_pkg::mdu_op_e       req_op_i,
    input  wire [`MDU_XLEN-1:0]         req_a_i,
    input  wire [`MDU_XLEN-1:0]         req_b_i,
    input  wire [`MDU_TAG_W-1:0]        req_tag_i,
    output logic                        req_credit_o,
    output logic                        res_valid_o,
    output logic [`MDU_XLEN-1:0]        res_data_o,
    output logic [`MDU_TAG_W-1:0]       res_tag_o,
    input  wire                         res_credit_i,
    input  wire                         cfg_we_i,
    input  wire                         cfg_addr_i,
    input  wire [`MDU_XLEN-1:0]         cfg_wdata_i,
    output logic [`MDU_XLEN-1:0]        cfg_rdata_o
);

    mdu_pkg::mdu_req_t          in_req;
    mdu_pkg::mdu_res_t          res;
    logic                       in_empty;
    logic                       in_pop;
    logic [`MDU_CRED_W-1:0]     credit_limit;

    mdu_op_if in_op ();

    assign in_req = '{op: req_op_i, a: req_a_i, b: req_b_i, tag: req_tag_i};

    mdu_fifo #(
        .T     (mdu_pkg::mdu_req_t),
        .DEPTH (`MDU_IN_DEPTH)
    ) u_in_fifo (
        .clk,
        .rst_n_i,
        .push_i      (req_valid_i),
        .push_data_i (in_req),
        .pop_i       (in_pop),
        .data_o      (in_op.req),
        .empty_o     (in_empty),
        .full_o      (),
        .count_o     ()
    );

    assign in_op.valid  = !in_empty;
    assign in_pop       = in_op.valid && in_op.ready;
    assign req_credit_o = in_pop; // one credit per popped entry

    mdu u_mdu (
        .clk,
        .rst_n_i,
        .op             (in_op.dst),
        .credit_limit_i (credit_limit),
        .res_credit_i,
        .res_valid_o,
        .res_o          (res)
    );

    assign res_data_o = res.data;
    assign res_tag_o  = res.tag;

    mdu_csr u_csr (
        .clk,
        .rst_n_i,
        .cfg_we_i,
        .cfg_addr_i,
        .cfg_wdata_i,
        .cfg_rdata_o,
        .res_valid_i    (res_valid_o),
        .credit_limit_o (credit_limit)
    );

endmodule

`default_nettype wire

/* mdu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_cfg.svh"

module mdu_tb;

    localparam int N_RAND   = 200;
    localparam int N_CORNER = 12;
    localparam int N_ORDER  = 9;
    localparam int N_BP     = 10;
    localparam int N_BURST  = 12;
    localparam int N_TOTAL  = N_RAND + N_CORNER + N_ORDER + N_BP + N_BURST;

    logic                           clk;
    logic                           rst_n_i;
    logic                           req_valid_i;
    mdu_pkg::mdu_op_e               req_op_i;
    logic [`MDU_XLEN-1:0]           req_a_i;
    logic [`MDU_XLEN-1:0]           req_b_i;
    logic [`MDU_TAG_W-1:0]          req_tag_i;
    logic                           req_credit_o;
    logic                           res_valid_o;
    logic [`MDU_XLEN-1:0]           res_data_o;
    logic [`MDU_TAG_W-1:0]          res_tag_o;
    logic                           res_credit_i;
    logic                           cfg_we_i;
    logic                           cfg_addr_i;
    logic [`MDU_XLEN-1:0]           cfg_wdata_i;
    logic [`MDU_XLEN-1:0]           cfg_rdata_o;

    logic [`MDU_XLEN+`MDU_TAG_W-1:0] exp_q [$]; // {data, tag} in issue order
    logic [`MDU_TAG_W-1:0]          next_tag;
    int                             credits;   // upstream credits held
    int                             held;      // results not yet credited back
    int                             cur_limit;
    logic                           credit_en;

    mdu_top DUT (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    // RV32M rules
    function automatic logic [31:0] model(input mdu_pkg::mdu_op_e op,
                                          input logic [31:0] a, input logic [31:0] b);
        logic [63:0] ss;
        logic [63:0] su;
        logic [63:0] uu;
        int          sa;
        int          sb;
        ss = {{32{a[31]}}, a} * {{32{b[31]}}, b}; // low 64 bits are exact
        su = {{32{a[31]}}, a} * {32'b0, b};
        uu = {32'b0, a} * {32'b0, b};
        sa = a;
        sb = b;
        case (op)
            mdu_pkg::MDU_MUL:    return ss[31:0];
            mdu_pkg::MDU_MULH:   return ss[63:32];
            mdu_pkg::MDU_MULHSU: return su[63:32];
            mdu_pkg::MDU_MULHU:  return uu[63:32];
            mdu_pkg::MDU_DIV: begin
                if (b == 0) return '1;
                if (a == 32'h8000_0000 && b == '1) return a;
                return sa / sb;
            end
            mdu_pkg::MDU_DIVU:   return (b == 0) ? '1 : a / b;
            mdu_pkg::MDU_REM: begin
                if (b == 0) return a;
                if (a == 32'h8000_0000 && b == '1) return '0;
                return sa % sb;
            end
            default:             return (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic logic [31:0] rand_operand();
        case ($urandom % 8)
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            default: return $urandom;
        endcase
    endfunction

    task automatic send_op(input mdu_pkg::mdu_op_e op, input logic [31:0] a,
                           input logic [31:0] b);
        while (credits == 0) begin
            @(posedge clk);
            #1;
        end
        req_valid_i = 1'b1;
        req_op_i    = op;
        req_a_i     = a;
        req_b_i     = b;
        req_tag_i   = next_tag;
        credits--;
        exp_q.push_back({model(op, a, b), next_tag});
        next_tag++;
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
    endtask

    task automatic send_random(input int n);
        repeat (n) send_op(mdu_pkg::mdu_op_e'($urandom % 8), rand_operand(), rand_operand());
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || held != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic cfg_write(input logic addr, input logic [31:0] data);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(posedge clk);
        #1;
        cfg_we_i = 1'b0;
    endtask

    task automatic cfg_expect(input logic addr, input logic [31:0] exp_v);
        cfg_addr_i = addr;
        #1;
        assert (cfg_rdata_o == exp_v) else
            abort_run($sformatf("MISMATCH %0t: cfg addr %0d read %0d, expected %0d",
                                $time, addr, cfg_rdata_o, exp_v));
        @(posedge clk);
        #1;
    endtask

    always @(negedge clk) begin : scoreboard
        logic [`MDU_XLEN+`MDU_TAG_W-1:0] exp_v;
        if (rst_n_i && req_credit_o) begin
            credits++;
        end
        if (rst_n_i && res_valid_o) begin
            if (exp_q.size() == 0) begin
                abort_run("a result came back with no request pending");
            end else begin
                exp_v = exp_q.pop_front();
                held++;
                assert ({res_data_o, res_tag_o} == exp_v) else
                    abort_run($sformatf("MISMATCH %0t: got tag %0d data %h, expected tag %0d data %h",
                                        $time, res_tag_o, res_data_o, exp_v[3:0], exp_v[35:4]));
            end
        end
    end

    initial begin : credit_return
        forever begin
            @(posedge clk);
            #1;
            res_credit_i = 1'b0;
            if (credit_en && held > 0 && ($urandom % 2 == 0)) begin
                res_credit_i = 1'b1; // random consumer delay
                held--;
            end
        end
    end

    a_down_credit: assert property (@(posedge clk) disable iff (!rst_n_i) held <= cur_limit)
        else abort_run($sformatf("more than %0d results outstanding at %0t", cur_limit, $time));
    a_up_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
        credits >= 0 && credits <= `MDU_IN_DEPTH)
        else abort_run("upstream credit count left its legal range");

    initial begin : watchdog
        repeat (N_TOTAL * 200 + 1000) @(posedge clk);
        abort_run("watchdog expired, the DUT stopped returning results");
    end

    initial begin : main
        void'($urandom(25033));
        rst_n_i      = 1'b0;
        req_valid_i  = 1'b0;
        req_op_i     = mdu_pkg::MDU_MUL;
        req_a_i      = '0;
        req_b_i      = '0;
        req_tag_i    = '0;
        res_credit_i = 1'b0;
        cfg_we_i     = 1'b0;
        cfg_addr_i   = 1'b0;
        cfg_wdata_i  = '0;
        next_tag     = '0;
        credits      = `MDU_IN_DEPTH;
        held         = 0;
        cur_limit    = `MDU_CREDITS_RST;
        credit_en    = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        send_random(N_RAND);
        drain();

        send_op(mdu_pkg::MDU_DIV,  32'd7, 32'd0);
        send_op(mdu_pkg::MDU_DIVU, 32'd9, 32'd0);
        send_op(mdu_pkg::MDU_REM,  32'hffff_fff9, 32'd0);
        send_op(mdu_pkg::MDU_REMU, 32'd5, 32'd0);
        send_op(mdu_pkg::MDU_DIV,  32'h8000_0000, 32'hffff_ffff);
        send_op(mdu_pkg::MDU_REM,  32'h8000_0000, 32'hffff_ffff);
        send_op(mdu_pkg::MDU_DIV,  32'hffff_fff9, 32'd2); // -7 / 2
        send_op(mdu_pkg::MDU_REM,  32'hffff_fff9, 32'd2);
        send_op(mdu_pkg::MDU_DIV,  32'd7, 32'hffff_fffe);
        send_op(mdu_pkg::MDU_REM,  32'hffff_fff9, 32'hffff_fffe);
        send_op(mdu_pkg::MDU_DIV,  32'd0, 32'd5);
        send_op(mdu_pkg::MDU_REMU, 32'd0, 32'd3);
        drain();

        // multiplies stream, the divide waits for them
        send_op(mdu_pkg::MDU_MUL,    $urandom, $urandom);
        send_op(mdu_pkg::MDU_MULH,   $urandom, $urandom);
        send_op(mdu_pkg::MDU_MULHSU, $urandom, $urandom);
        send_op(mdu_pkg::MDU_MULHU,  $urandom, $urandom);
        send_op(mdu_pkg::MDU_DIV,    $urandom, 32'd3);
        send_op(mdu_pkg::MDU_MUL,    $urandom, $urandom);
        send_op(mdu_pkg::MDU_MULHU,  $urandom, $urandom);
        send_op(mdu_pkg::MDU_MULH,   $urandom, $urandom);
        send_op(mdu_pkg::MDU_MUL,    $urandom, $urandom);
        drain();

        credit_en = 1'b0; // receiver stalls
        send_random(N_BP);
        repeat (400) @(posedge clk);
        #1;
        assert (held == cur_limit) else
            abort_run("results sent without credit do not match the credit limit");
        credit_en = 1'b1;
        drain();

        cfg_write(1'b0, 32'd7);
        cfg_expect(1'b0, `MDU_RES_DEPTH); // saturated
        cfg_write(1'b0, 32'd1);
        cur_limit = 1;
        cfg_expect(1'b0, 32'd1);
        send_random(N_BURST);
        drain();
        cfg_expect(1'b1, N_TOTAL);
        assert (credits == `MDU_IN_DEPTH) else
            abort_run("not all upstream credits came back at the end of the run");

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* mdu_top.f */
+incdir+.
mdu_pkg.sv
mdu_op_if.sv
mdu_fifo.sv
mdu_muler.sv
mdu_diver.sv
mdu.sv
mdu_csr.sv
mdu_top.sv
mdu_tb.sv

/* Makefile */
TOP = mdu_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f mdu_top.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
